//--- logic/crop_top.sv
`timescale 1ns/1ps
`include "video_consts.svh"

module crop_top
	import video_pkg::*;
(
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          wr_en,
	input  logic [`VID_REG_ADDR_BITS-1:0] wr_addr,
	input  logic [`VID_REG_DATA_BITS-1:0] wr_data,
	input  logic                          rd_en,
	input  logic [`VID_REG_ADDR_BITS-1:0] rd_addr,
	output logic [`VID_REG_DATA_BITS-1:0] rd_data,
	output logic                          fsync,
	output logic                          s0_soft_resetn,
	output logic                          st_soft_resetn,
	input  logic                          s0_tvalid,
	input  pixel_gray_t                   s0_tdata,
	input  logic                          s0_tuser,
	input  logic                          s0_tlast,
	output logic                          s0_tready,
	input  logic                          st_tvalid,
	input  pixel_argb_t                   st_tdata,
	input  logic                          st_tuser,
	input  logic                          st_tlast,
	output logic                          st_tready,
	output logic                          m0_tvalid,
	output pixel_gray_t                   m0_tdata,
	output logic                          m0_tuser,
	output logic                          m0_tlast,
	input  logic                          m0_tready,
	output logic                          mt_tvalid,
	output pixel_argb_t                   mt_tdata,
	output logic                          mt_tuser,
	output logic                          mt_tlast,
	input  logic                          mt_tready
);

	logic                          run;
	logic [`VID_REG_DATA_BITS-1:0] period;
	img_dim_t                      s0_width, s0_height, s0_left, s0_top, s0_win_w, s0_win_h;
	img_dim_t                      st_width, st_height, st_left, st_top, st_win_w, st_win_h;
	logic                          s0_frame_done;
	logic                          st_frame_done;

	// ======================================================================
	// control and timing
	// ======================================================================
	ctl_regs u_ctl_regs (
		.clk            (clk),
		.resetn         (resetn),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.rd_en          (rd_en),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.run            (run),
		.period         (period),
		.s0_soft_resetn (s0_soft_resetn),
		.st_soft_resetn (st_soft_resetn),
		.s0_width       (s0_width),
		.s0_height      (s0_height),
		.s0_left        (s0_left),
		.s0_top         (s0_top),
		.s0_win_w       (s0_win_w),
		.s0_win_h       (s0_win_h),
		.st_width       (st_width),
		.st_height      (st_height),
		.st_left        (st_left),
		.st_top         (st_top),
		.st_win_w       (st_win_w),
		.st_win_h       (st_win_h),
		.s0_frame_done  (s0_frame_done),
		.st_frame_done  (st_frame_done)
	);

	fsync_gen u_fsync_gen (
		.clk    (clk),
		.resetn (resetn),
		.run    (run),
		.period (period),
		.fsync  (fsync)
	);

	// ======================================================================
	// croppers
	// ======================================================================
	stream_crop #(.pixel_t(pixel_gray_t)) u_crop_s0 (
		.clk (clk), .resetn (resetn), .fsync (fsync), .soft_resetn (s0_soft_resetn),
		.width (s0_width), .height (s0_height), .left (s0_left), .top (s0_top),
		.win_w (s0_win_w), .win_h (s0_win_h),
		.s_tvalid (s0_tvalid), .s_tdata (s0_tdata), .s_tuser (s0_tuser),
		.s_tlast (s0_tlast), .s_tready (s0_tready),
		.m_tvalid (m0_tvalid), .m_tdata (m0_tdata), .m_tuser (m0_tuser),
		.m_tlast (m0_tlast), .m_tready (m0_tready),
		.frame_done (s0_frame_done)
	);

	stream_crop #(.pixel_t(pixel_argb_t)) u_crop_st ( // colour stream
		.clk (clk), .resetn (resetn), .fsync (fsync), .soft_resetn (st_soft_resetn),
		.width (st_width), .height (st_height), .left (st_left), .top (st_top),
		.win_w (st_win_w), .win_h (st_win_h),
		.s_tvalid (st_tvalid), .s_tdata (st_tdata), .s_tuser (st_tuser),
		.s_tlast (st_tlast), .s_tready (st_tready),
		.m_tvalid (mt_tvalid), .m_tdata (mt_tdata), .m_tuser (mt_tuser),
		.m_tlast (mt_tlast), .m_tready (mt_tready),
		.frame_done (st_frame_done)
	);

endmodule

//--- logic/ctl_regs.sv
`timescale 1ns/1ps
`include "video_consts.svh"

module ctl_regs
	import video_pkg::*;
(
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           wr_en,
	input  logic [`VID_REG_ADDR_BITS-1:0]  wr_addr,
	input  logic [`VID_REG_DATA_BITS-1:0]  wr_data,
	input  logic                           rd_en,
	input  logic [`VID_REG_ADDR_BITS-1:0]  rd_addr,
	output logic [`VID_REG_DATA_BITS-1:0]  rd_data,
	output logic                           run,
	output logic [`VID_REG_DATA_BITS-1:0]  period,
	output logic                           s0_soft_resetn,
	output logic                           st_soft_resetn,
	output img_dim_t                       s0_width,
	output img_dim_t                       s0_height,
	output img_dim_t                       s0_left,
	output img_dim_t                       s0_top,
	output img_dim_t                       s0_win_w,
	output img_dim_t                       s0_win_h,
	output img_dim_t                       st_width,
	output img_dim_t                       st_height,
	output img_dim_t                       st_left,
	output img_dim_t                       st_top,
	output img_dim_t                       st_win_w,
	output img_dim_t                       st_win_h,
	input  logic                           s0_frame_done,
	input  logic                           st_frame_done
);

	logic [1:0]  ctl_q;     // {flush, run}
	logic [1:0]  strm_en_q; // {stream t, stream 0}
	logic [15:0] s0_frames;
	logic [15:0] st_frames;

	// upper half holds the first field, lower half the second
	function automatic logic [`VID_REG_DATA_BITS-1:0] pack_dims(img_dim_t hi, img_dim_t lo);
		logic [`VID_REG_DATA_BITS-1:0] word;
		word = '0;
		word[16 +: `VID_IMG_BITS] = hi;
		word[0 +: `VID_IMG_BITS]  = lo;
		return word;
	endfunction

	assign run            = ctl_q[0];
	assign s0_soft_resetn = ctl_q[0] && strm_en_q[0] && !ctl_q[1];
	assign st_soft_resetn = ctl_q[0] && strm_en_q[1] && !ctl_q[1];

	// ======================================================================
	// write path
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ctl_q     <= '0;
			strm_en_q <= '0;
			period    <= '0;
			s0_width  <= '0;
			s0_height <= '0;
			s0_left   <= '0;
			s0_top    <= '0;
			s0_win_w  <= '0;
			s0_win_h  <= '0;
			st_width  <= '0;
			st_height <= '0;
			st_left   <= '0;
			st_top    <= '0;
			st_win_w  <= '0;
			st_win_h  <= '0;
		end else if (wr_en) begin
			case (wr_addr)
				`VID_ADDR_CTL:     ctl_q     <= wr_data[1:0];
				`VID_ADDR_STRM_EN: strm_en_q <= wr_data[1:0];
				`VID_ADDR_PERIOD:  period    <= wr_data;
				`VID_ADDR_S0_SIZE: begin
					s0_width  <= wr_data[16 +: `VID_IMG_BITS];
					s0_height <= wr_data[0 +: `VID_IMG_BITS];
				end
				`VID_ADDR_S0_ORG: begin
					s0_left <= wr_data[16 +: `VID_IMG_BITS];
					s0_top  <= wr_data[0 +: `VID_IMG_BITS];
				end
				`VID_ADDR_S0_WIN: begin
					s0_win_w <= wr_data[16 +: `VID_IMG_BITS];
					s0_win_h <= wr_data[0 +: `VID_IMG_BITS];
				end
				`VID_ADDR_ST_SIZE: begin
					st_width  <= wr_data[16 +: `VID_IMG_BITS];
					st_height <= wr_data[0 +: `VID_IMG_BITS];
				end
				`VID_ADDR_ST_ORG: begin
					st_left <= wr_data[16 +: `VID_IMG_BITS];
					st_top  <= wr_data[0 +: `VID_IMG_BITS];
				end
				`VID_ADDR_ST_WIN: begin
					st_win_w <= wr_data[16 +: `VID_IMG_BITS];
					st_win_h <= wr_data[0 +: `VID_IMG_BITS];
				end
				default: ; // frames and unmapped addresses
			endcase
		end
	end

	// frame counters, wrap at 16 bits
	always_ff @(posedge clk) begin
		if (!resetn) begin
			s0_frames <= '0;
			st_frames <= '0;
		end else begin
			if (s0_frame_done)
				s0_frames <= s0_frames + 1'b1;
			if (st_frame_done)
				st_frames <= st_frames + 1'b1;
		end
	end

	// ======================================================================
	// read path
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_data <= '0;
		end else if (rd_en) begin
			case (rd_addr)
				`VID_ADDR_CTL:     rd_data <= {30'd0, ctl_q};
				`VID_ADDR_STRM_EN: rd_data <= {30'd0, strm_en_q};
				`VID_ADDR_PERIOD:  rd_data <= period;
				`VID_ADDR_FRAMES:  rd_data <= {st_frames, s0_frames};
				`VID_ADDR_S0_SIZE: rd_data <= pack_dims(s0_width, s0_height);
				`VID_ADDR_S0_ORG:  rd_data <= pack_dims(s0_left, s0_top);
				`VID_ADDR_S0_WIN:  rd_data <= pack_dims(s0_win_w, s0_win_h);
				`VID_ADDR_ST_SIZE: rd_data <= pack_dims(st_width, st_height);
				`VID_ADDR_ST_ORG:  rd_data <= pack_dims(st_left, st_top);
				`VID_ADDR_ST_WIN:  rd_data <= pack_dims(st_win_w, st_win_h);
				default:           rd_data <= '0;
			endcase
		end
	end

	// a shorter period would let fsync fire before a frame can be armed
	period_min_check: assert property (@(posedge clk) disable iff (!resetn)
		(wr_en && wr_addr == `VID_ADDR_PERIOD) |-> (wr_data >= `VID_MIN_PERIOD));

endmodule

//--- logic/fsync_gen.sv
`timescale 1ns/1ps
`include "video_consts.svh"

module fsync_gen (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          run,
	input  logic [`VID_REG_DATA_BITS-1:0] period,
	output logic                          fsync
);

	logic [`VID_REG_DATA_BITS-1:0] cnt;
	logic                          pulse;

	// ======================================================================
	// period down-counter
	// ======================================================================
	// while stopped the counter keeps tracking period, so the first pulse
	// lands exactly period cycles after run goes high
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt   <= '0;
			pulse <= 1'b0;
		end else if (!run) begin
			cnt   <= period;
			pulse <= 1'b0;
		end else if (cnt <= 1) begin
			cnt   <= period; // expiry, reload
			pulse <= 1'b1;
		end else begin
			cnt   <= cnt - 1'b1;
			pulse <= 1'b0;
		end
	end

	assign fsync = pulse && run; // clearing run kills a pending pulse

	fsync_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
		fsync |=> !fsync);

endmodule

//--- logic/stream_crop.sv
`timescale 1ns/1ps
`include "video_consts.svh"

module stream_crop
	import video_pkg::*;
#(
	parameter type pixel_t = pixel_gray_t
)
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     fsync,
	input  logic     soft_resetn,
	input  img_dim_t width,
	input  img_dim_t height,
	input  img_dim_t left,
	input  img_dim_t top,
	input  img_dim_t win_w,
	input  img_dim_t win_h,
	input  logic     s_tvalid,
	input  pixel_t   s_tdata,
	input  logic     s_tuser,
	input  logic     s_tlast,
	output logic     s_tready,
	output logic     m_tvalid,
	output pixel_t   m_tdata,
	output logic     m_tuser,
	output logic     m_tlast,
	input  logic     m_tready,
	output logic     frame_done
);

	localparam int END_BITS = `VID_IMG_BITS + 1; // window ends may pass the field range

	img_dim_t              width_q;
	img_dim_t              height_q;
	img_dim_t              left_q;
	img_dim_t              top_q;
	logic [END_BITS-1:0]   right_q;  // first column past the window
	logic [END_BITS-1:0]   bottom_q; // first row past the window
	img_dim_t              row;
	img_dim_t              col;
	logic                  active;
	logic                  xfer;
	logic                  col_last;
	logic                  row_last;
	logic                  in_win;
	logic                  win_first;
	logic                  win_last;

	assign s_tready = active && (!m_tvalid || m_tready); // room once the held pixel leaves
	assign xfer     = s_tvalid && s_tready;

	assign col_last  = (col == width_q - 1'b1);
	assign row_last  = (row == height_q - 1'b1);
	assign in_win    = (row >= top_q) && ({1'b0, row} < bottom_q)
		&& (col >= left_q) && ({1'b0, col} < right_q);
	assign win_first = (row == top_q) && (col == left_q);
	assign win_last  = ({1'b0, col} + 1'b1 == right_q);

	// ======================================================================
	// frame arming and position tracking
	// ======================================================================
	// settings are sampled once per frame, mid-frame writes wait for the next
	always_ff @(posedge clk) begin
		if (fsync && soft_resetn && !active) begin
			width_q  <= width;
			height_q <= height;
			left_q   <= left;
			top_q    <= top;
			right_q  <= {1'b0, left} + win_w;
			bottom_q <= {1'b0, top} + win_h;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || !soft_resetn) begin
			active     <= 1'b0;
			row        <= '0;
			col        <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (!active) begin
				if (fsync) begin
					active <= 1'b1;
					row    <= '0;
					col    <= '0;
				end
			end else if (xfer) begin
				if (col_last) begin
					col <= '0;
					if (row_last) begin
						active     <= 1'b0; // frame complete
						row        <= '0;
						frame_done <= 1'b1;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// ======================================================================
	// output register
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!resetn || !soft_resetn)
			m_tvalid <= 1'b0;
		else if (xfer && in_win)
			m_tvalid <= 1'b1;
		else if (m_tready)
			m_tvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (xfer && in_win) begin
			m_tdata <= s_tdata;
			m_tuser <= win_first;
			m_tlast <= win_last;
		end
	end

	in_user_at_origin: assert property (@(posedge clk) disable iff (!resetn || !soft_resetn)
		(xfer && s_tuser) |-> (row == '0 && col == '0));

	in_last_at_line_end: assert property (@(posedge clk) disable iff (!resetn || !soft_resetn)
		(xfer && s_tlast) |-> col_last);

	out_hold_stable: assert property (@(posedge clk) disable iff (!resetn || !soft_resetn)
		(m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)));

endmodule

//--- logic/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ======================================================================
// field widths
// ======================================================================
`define VID_IMG_BITS       12 // row, column and dimension fields
`define VID_REG_ADDR_BITS  8
`define VID_REG_DATA_BITS  32

// ======================================================================
// register map
// ======================================================================
`define VID_ADDR_CTL       8'd0 // bit0 run, bit1 flush
`define VID_ADDR_STRM_EN   8'd1
`define VID_ADDR_PERIOD    8'd2
`define VID_ADDR_FRAMES    8'd3 // read only
`define VID_ADDR_S0_SIZE   8'd5
`define VID_ADDR_S0_ORG    8'd6
`define VID_ADDR_S0_WIN    8'd7
`define VID_ADDR_ST_SIZE   8'd4
`define VID_ADDR_ST_ORG    8'd8
`define VID_ADDR_ST_WIN    8'd9

`define VID_MIN_PERIOD     16 // shortest legal frame-sync period in cycles

`endif

//--- logic/video_pkg.sv
`include "video_consts.svh"

package video_pkg;

	// ======================================================================
	// geometry
	// ======================================================================

	// row, column, width or height of a frame or window
	typedef logic [`VID_IMG_BITS-1:0] img_dim_t;

	// ======================================================================
	// pixel payloads
	// ======================================================================

	typedef logic [7:0] pixel_gray_t; // single luma byte

	// alpha, red, green, blue from msb down
	typedef logic [31:0] pixel_argb_t;

endpackage

//--- src.f
+incdir+logic
logic/video_pkg.sv
logic/ctl_regs.sv
logic/fsync_gen.sv
logic/stream_crop.sv
logic/crop_top.sv
tb/tb_crop_top.sv

//--- tb/crop_vectors.txt
// per line, in hex: period strm_en | s0: width height left top win_w win_h |
// st: width height left top win_w win_h | gaps midwin frames exp_m0 exp_mt
60  3  8 6 0 0 8 6  6 4 0 0 6 4  0 0 2 60 30
80  3  a 8 2 1 5 4  c 6 3 2 6 3  0 0 3 3c 36
100 3  8 8 1 1 6 5  7 5 0 2 7 3  1 0 2 3c 2a
c0  3  6 6 2 3 4 3  9 4 5 1 4 3  1 0 3 24 24
80  3  8 6 2 2 3 2  6 5 1 1 4 3  0 1 3 66 48
80  1  8 4 0 0 8 4  6 4 1 1 2 2  1 0 2 40 0
40  2  4 4 0 0 4 4  5 5 1 0 3 5  0 0 2 0 1e

//--- tb/tb_crop_top.sv
`timescale 1ns/1ps
`include "video_consts.svh"

module tb_crop_top
	import video_pkg::*;
();

	localparam int COLS      = 19; // values per vector line
	localparam int MAX_TESTS = 16;
	localparam int C_EN      = 1;
	localparam int C_GAPS    = 14;
	localparam int C_MID     = 15;
	localparam int C_FRAMES  = 16;
	localparam int C_EXP     = 17; // expected counts for stream 0 then stream t

	logic                          clk, resetn, wr_en, rd_en;
	logic [`VID_REG_ADDR_BITS-1:0] wr_addr, rd_addr;
	logic [`VID_REG_DATA_BITS-1:0] wr_data, rd_data;
	logic                          fsync, s0_soft_resetn, st_soft_resetn;
	logic                          s0_tvalid, s0_tuser, s0_tlast, s0_tready;
	logic                          st_tvalid, st_tuser, st_tlast, st_tready;
	logic                          m0_tvalid, m0_tuser, m0_tlast, m0_tready;
	logic                          mt_tvalid, mt_tuser, mt_tlast, mt_tready;
	pixel_gray_t                   s0_tdata, m0_tdata;
	pixel_argb_t                   st_tdata, mt_tdata;

	logic [31:0] vec_mem [0:MAX_TESTS*COLS-1];
	int          vec [0:COLS-1]; // line of the running test
	int          out_count [0:1];
	int          off_active [0:1]; // cycles a disabled stream spent out of soft reset
	int          exp_frames [0:1];
	int          test_errors, tests_passed, tests_failed, num_tests;
	longint      wd_cycles;
	bit          gaps_on, wd_armed;

	crop_top u_crop_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		m0_tready = !gaps_on || ($urandom % 4 != 0);
		mt_tready = !gaps_on || ($urandom % 4 != 0);
	end

	always @(posedge clk) begin
		if (m0_tvalid && m0_tready)
			out_count[0]++;
		if (mt_tvalid && mt_tready)
			out_count[1]++;
		if (!(vec[C_EN] & 1) && (s0_soft_resetn || s0_tready))
			off_active[0]++;
		if (!(vec[C_EN] & 2) && (st_soft_resetn || st_tready))
			off_active[1]++;
	end

	initial begin
		wait (wd_armed);
		#(wd_cycles * 4);
		$display("watchdog expired after %0d cycles, a stream stalled", wd_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ======================================================================
	// helpers
	// ======================================================================
	function automatic logic [31:0] reg_word(input int hi, input int lo);
		return ((hi & 32'hfff) << 16) | (lo & 32'hfff);
	endfunction

	// row*16 + column, plus 256 per stream index, cut to the pixel width
	function automatic logic [31:0] pixel_value(input int s, input int r, input int c);
		logic [31:0] v;
		v = r * 16 + c + s * 256;
		return (s == 0) ? (v & 32'hff) : v;
	endfunction

	task automatic reg_write(input int addr, input logic [31:0] data);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic reg_read(input int addr, output logic [31:0] data);
		rd_en   = 1'b1;
		rd_addr = addr;
		@(posedge clk);
		#1;
		rd_en = 1'b0;
		data  = rd_data;
	endtask

	task automatic drive_pixel(input int s, input logic v, input logic [31:0] d,
		input logic u, input logic l);
		if (s == 0) begin
			s0_tvalid = v;
			s0_tdata  = d[7:0];
			s0_tuser  = u;
			s0_tlast  = l;
		end else begin
			st_tvalid = v;
			st_tdata  = d;
			st_tuser  = u;
			st_tlast  = l;
		end
	endtask

	// midwin lines switch to the full frame from the second frame on
	task automatic get_window(input int s, input int f, output int left, top, ww, wh);
		int b;
		bit full;
		b    = 2 + 6 * s;
		full = vec[C_MID] != 0 && f > 0;
		left = full ? 0 : vec[b + 2];
		top  = full ? 0 : vec[b + 3];
		ww   = full ? vec[b] : vec[b + 4];
		wh   = full ? vec[b + 1] : vec[b + 5];
	endtask

	// ======================================================================
	// register checks
	// ======================================================================
	task automatic check_registers();
		logic [31:0] data, value;
		logic [6:0]  idle;
		int a;
		repeat (20) begin
			@(posedge clk);
			idle = {fsync, s0_soft_resetn, st_soft_resetn, m0_tvalid, mt_tvalid,
				s0_tready, st_tready};
			if (idle !== 7'd0) begin
				$display("** Error: idle outputs = 0x%h, expected 0x00", idle);
				test_errors++;
			end
		end
		#1;
		for (a = 0; a < 10; a++) begin
			reg_read(a, data);
			if (data !== 32'd0) begin
				$display("** Error: rd_data at 0x%h = 0x%h after reset, expected 0x0", a, data);
				test_errors++;
			end
			case (a)
				0:       value = 32'h2; // flush holds both streams in soft reset
				1:       value = 32'h3;
				2:       value = 32'h1234;
				3:       value = 32'hdead_beef;
				default: value = reg_word(a * 32'h111, a * 32'h21);
			endcase
			reg_write(a, value);
			reg_read(a, data);
			if (a == 3)
				value = 32'd0; // frame counters are read only
			if (data !== value) begin
				$display("** Error: rd_data at 0x%h = 0x%h, expected 0x%h", a, data, value);
				test_errors++;
			end
		end
		reg_write(`VID_ADDR_CTL, 0);
		reg_write(`VID_ADDR_STRM_EN, 0);
	endtask

	// ======================================================================
	// sources and checkers
	// ======================================================================
	task automatic send_frames(input int s);
		int f, r, c, w, h;
		w = vec[2 + 6 * s];
		h = vec[3 + 6 * s];
		for (f = 0; f < vec[C_FRAMES]; f++) begin
			do @(posedge clk); while (!(fsync && (s == 0 ? s0_soft_resetn : st_soft_resetn)));
			#1;
			for (r = 0; r < h; r++) begin
				for (c = 0; c < w; c++) begin
					while (gaps_on && ($urandom % 4 == 0)) begin
						drive_pixel(s, 0, 0, 0, 0);
						@(posedge clk);
						#1;
					end
					drive_pixel(s, 1, pixel_value(s, r, c), r == 0 && c == 0, c == w - 1);
					do @(posedge clk); while (!(s == 0 ? s0_tready : st_tready));
					#1;
				end
			end
			drive_pixel(s, 0, 0, 0, 0);
		end
	endtask

	task automatic check_frames(input int s);
		int f, r, c, left, top, ww, wh;
		logic [31:0] got, exp_d;
		logic got_u, got_l, exp_u, exp_l;
		string name;
		name = (s == 0) ? "m0" : "mt";
		for (f = 0; f < vec[C_FRAMES]; f++) begin
			get_window(s, f, left, top, ww, wh);
			for (r = 0; r < wh; r++) begin
				for (c = 0; c < ww; c++) begin
					do @(posedge clk);
					while (s == 0 ? !(m0_tvalid && m0_tready) : !(mt_tvalid && mt_tready));
					got   = (s == 0) ? {24'd0, m0_tdata} : mt_tdata;
					got_u = (s == 0) ? m0_tuser : mt_tuser;
					got_l = (s == 0) ? m0_tlast : mt_tlast;
					exp_d = pixel_value(s, top + r, left + c);
					exp_u = (r == 0 && c == 0);
					exp_l = (c == ww - 1);
					if (got !== exp_d) begin
						$display("** Error: %s_tdata = 0x%h, expected 0x%h", name, got, exp_d);
						test_errors++;
					end
					if (got_u !== exp_u) begin
						$display("** Error: %s_tuser = 0x%h, expected 0x%h", name, got_u, exp_u);
						test_errors++;
					end
					if (got_l !== exp_l) begin
						$display("** Error: %s_tlast = 0x%h, expected 0x%h", name, got_l, exp_l);
						test_errors++;
					end
				end
			end
		end
	endtask

	task automatic move_windows();
		do @(posedge clk); while (!fsync);
		repeat (3) @(posedge clk); // well inside the first frame
		#1;
		reg_write(`VID_ADDR_S0_ORG, 0);
		reg_write(`VID_ADDR_S0_WIN, reg_word(vec[2], vec[3]));
		reg_write(`VID_ADDR_ST_ORG, 0);
		reg_write(`VID_ADDR_ST_WIN, reg_word(vec[8], vec[9]));
	endtask

	task automatic run_test(input int t);
		logic [31:0] data, exp_data;
		int k;
		for (k = 0; k < COLS; k++)
			vec[k] = vec_mem[t * COLS + k];
		gaps_on = vec[C_GAPS] != 0;
		reg_write(`VID_ADDR_PERIOD, vec[0]);
		reg_write(`VID_ADDR_STRM_EN, vec[C_EN]);
		reg_write(`VID_ADDR_S0_SIZE, reg_word(vec[2], vec[3]));
		reg_write(`VID_ADDR_S0_ORG, reg_word(vec[4], vec[5]));
		reg_write(`VID_ADDR_S0_WIN, reg_word(vec[6], vec[7]));
		reg_write(`VID_ADDR_ST_SIZE, reg_word(vec[8], vec[9]));
		reg_write(`VID_ADDR_ST_ORG, reg_word(vec[10], vec[11]));
		reg_write(`VID_ADDR_ST_WIN, reg_word(vec[12], vec[13]));
		out_count[0]  = 0;
		out_count[1]  = 0;
		off_active[0] = 0;
		off_active[1] = 0;
		reg_write(`VID_ADDR_CTL, 1);
		fork
			if (vec[C_EN] & 1) send_frames(0);
			if (vec[C_EN] & 1) check_frames(0);
			if (vec[C_EN] & 2) send_frames(1);
			if (vec[C_EN] & 2) check_frames(1);
			if (vec[C_MID] != 0) move_windows();
		join
		repeat (20) @(posedge clk); // stray output would land in the counts
		#1;
		reg_write(`VID_ADDR_CTL, 0);
		for (k = 0; k < 2; k++) begin
			if (out_count[k] != vec[C_EXP + k]) begin
				$display("** Error: stream %0d pixel count = 0x%h, expected 0x%h",
					k, out_count[k], vec[C_EXP + k]);
				test_errors++;
			end
			if (off_active[k] != 0) begin
				$display("stream %0d left soft reset for %0d cycles while disabled",
					k, off_active[k]);
				test_errors++;
			end
			if (vec[C_EN] & (1 << k))
				exp_frames[k] += vec[C_FRAMES];
		end
		reg_read(`VID_ADDR_FRAMES, data);
		exp_data = (exp_frames[1] << 16) | (exp_frames[0] & 32'hffff);
		if (data !== exp_data) begin
			$display("** Error: rd_data FRAMES = 0x%h, expected 0x%h", data, exp_data);
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, test_errors);
		end
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		int t;
		void'($urandom(32'h5697_c181));
		resetn   = 1'b0;
		wr_en    = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		rd_en    = 1'b0;
		rd_addr  = '0;
		drive_pixel(0, 0, 0, 0, 0);
		drive_pixel(1, 0, 0, 0, 0);
		m0_tready     = 1'b0;
		mt_tready     = 1'b0;
		gaps_on       = 1'b0;
		out_count[0]  = 0;
		out_count[1]  = 0;
		off_active[0] = 0;
		off_active[1] = 0;
		exp_frames[0] = 0;
		exp_frames[1] = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		$readmemh("tb/crop_vectors.txt", vec_mem);
		num_tests = 0;
		wd_cycles = 3000;
		while (num_tests < MAX_TESTS && vec_mem[num_tests * COLS] !== 'x
			&& vec_mem[num_tests * COLS] != 0) begin
			wd_cycles += vec_mem[num_tests * COLS + C_FRAMES] * vec_mem[num_tests * COLS] * 4;
			num_tests++;
		end
		wd_armed = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		resetn      = 1'b1;
		test_errors = 0;
		check_registers();
		report_test("reset and registers");
		for (t = 0; t < num_tests; t++) begin
			test_errors = 0;
			run_test(t);
			report_test($sformatf("vector %0d", t));
		end
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
